// ==== Makefile ====
# Verilator build and run of the store-stream sink testbench.

VERILATOR ?= verilator
TOP       ?= tb_sink
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP), passes on '$(PASS_MSG)'"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_clkgen.sv ====
/*
 * Testbench clock and reset source.
 * 20 ns clock, active-low reset held for 8 rising edges.
 */

`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o; // 20 ns period.
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #2 rst_no = 1'b1; // release off the edge.
  end

endmodule

`default_nettype wire

// ==== dv/tb_sink.sv ====
/*
 * Testbench of sink_top.
 * Programs the address pattern over APB, feeds a stream with random gaps,
 * grants stores from a memory model and checks every store against
 * exp_addr and the sent beats. Stops at the first mismatch.
 */

`default_nettype none

module tb_sink;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TOTAL_BEATS    = 47;                    // sum over all transfers.
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_BEATS + 2000;

  logic clk_i, rst_ni;
  logic psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  sink_pkg::apb_addr_t paddr_i;
  sink_pkg::data_t     pwdata_i, prdata_o, stream_data_i, mem_data_o;
  logic stream_valid_i, stream_ready_o, mem_req_o;
  logic mem_gnt_i = 1'b0;
  sink_pkg::strb_t  stream_strb_i, mem_be_o;
  sink_pkg::addr_t  mem_addr_o;

  int  seed = 27382;
  int  cycle_cnt = 0;
  int  store_cnt = 0;    // all stores seen since reset.
  int  first_store, exp_n;
  bit  bp_mode = 1'b0;   // random grants when set.
  logic apb_err;
  string test_name = "none";
  sink_pkg::data_t  prev_done;
  sink_pkg::addr_t  cfg_base, cfg_stride;
  sink_pkg::count_t cfg_len;
  sink_pkg::data_t  exp_data [64];
  sink_pkg::strb_t  exp_strb [64];

  tb_clkgen u_clkgen (.clk_o(clk_i), .rst_no(rst_ni));

  sink_top #(.STORE_FIFO_DEPTH(4)) u_dut (.*);

  // ********************
  // reporting and compares.
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped at first failure.");
  endtask

  task automatic check_addr(input string what, input sink_pkg::addr_t exp, act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected 0x%08h, actual 0x%08h",
                               test_name, what, exp, act));
  endtask

  task automatic check_data(input string what, input sink_pkg::data_t exp, act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected 0x%08h, actual 0x%08h",
                               test_name, what, exp, act));
  endtask

  task automatic check_strb(input string what, input sink_pkg::strb_t exp, act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected 0x%h, actual 0x%h",
                               test_name, what, exp, act));
  endtask

  task automatic check_count(input string what, input sink_pkg::data_t exp, act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
  endtask

  // beat k lands at base + line * stride + word * 4.
  function automatic sink_pkg::addr_t exp_addr(input int unsigned k);
    sink_pkg::addr_t line, word;
    line = sink_pkg::addr_t'(k) / sink_pkg::addr_t'(cfg_len);
    word = sink_pkg::addr_t'(k) % sink_pkg::addr_t'(cfg_len);
    return cfg_base + line * cfg_stride + (word << 2);
  endfunction

  // ********************
  // apb driver samples the reply mid-cycle in the access phase.
  task automatic apb_access(input sink_pkg::apb_addr_t addr, input logic wr,
                            input sink_pkg::data_t wdata, output sink_pkg::data_t rdata);
    @(posedge clk_i);
    #2 psel_i = 1'b1; // setup phase.
    pwrite_i = wr;
    paddr_i  = addr;
    pwdata_i = wdata;
    @(posedge clk_i);
    #2 penable_i = 1'b1;
    @(negedge clk_i);
    rdata   = prdata_o;
    apb_err = pslverr_o;
    check_count("pready", 1, {31'h0, pready_o}); // no wait states.
    @(posedge clk_i);
    #2 psel_i = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input sink_pkg::apb_addr_t addr, input sink_pkg::data_t wdata);
    sink_pkg::data_t unused_rd;
    apb_access(addr, 1'b1, wdata, unused_rd);
  endtask

  task automatic apb_read(input sink_pkg::apb_addr_t addr, output sink_pkg::data_t rdata);
    apb_access(addr, 1'b0, '0, rdata);
  endtask

  // ********************
  // stream driver holds valid until ready is seen.
  task automatic send_stream(input int n);
    int gap;
    @(posedge clk_i);
    #2;
    for (int k = 0; k < n; k++) begin
      gap = {$random(seed)} % 3;
      if (gap != 0) begin
        stream_valid_i = 1'b0;
        repeat (gap) @(posedge clk_i);
        #2;
      end
      stream_valid_i = 1'b1;
      stream_data_i  = exp_data[k];
      stream_strb_i  = exp_strb[k];
      do @(negedge clk_i); while (!stream_ready_o); // ready depends on registers only.
      @(posedge clk_i);
      #2;
    end
    stream_valid_i = 1'b0;
  endtask

  // memory model grants after the edge and logs each store mid-cycle.
  always @(posedge clk_i) begin
    #2 mem_gnt_i = bp_mode ? (({$random(seed)} % 2) == 0) : 1'b1;
  end

  always @(negedge clk_i) begin
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      if (store_cnt - first_store >= exp_n)
        report_failure($sformatf("%s: store to 0x%08h beyond the transfer size",
                                 test_name, mem_addr_o));
      check_addr("store addr", exp_addr(store_cnt - first_store), mem_addr_o);
      check_data("store data", exp_data[store_cnt - first_store], mem_data_o);
      check_strb("store be", exp_strb[store_cnt - first_store], mem_be_o);
      store_cnt = store_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      report_failure($sformatf("timeout: the sink did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
  end

  // ********************
  // transfer sequencing.
  task automatic setup_transfer(input string name, input sink_pkg::addr_t base,
                                input int size, input sink_pkg::count_t len,
                                input sink_pkg::addr_t stride);
    sink_pkg::data_t rd;
    test_name  = name;
    cfg_base   = base;
    cfg_len    = len;
    cfg_stride = stride;
    for (int k = 0; k < size; k++) begin
      exp_data[k] = sink_pkg::data_t'($random(seed));
      exp_strb[k] = sink_pkg::strb_t'($random(seed));
    end
    exp_n       = size;
    first_store = store_cnt;
    apb_read(sink_pkg::REG_STATUS, rd);
    prev_done = {16'h0, rd[31:16]};
    apb_write(sink_pkg::REG_BASE, base);
    apb_write(sink_pkg::REG_TRANS_SIZE, sink_pkg::data_t'(size));
    apb_write(sink_pkg::REG_LINE_LEN, {16'h0, len});
    apb_write(sink_pkg::REG_LINE_STRIDE, stride);
  endtask

  task automatic finish_transfer();
    sink_pkg::data_t rd;
    fork
      send_stream(exp_n);
      do apb_read(sink_pkg::REG_STATUS, rd); while (rd[0]); // poll busy.
    join
    check_count("stores", sink_pkg::data_t'(exp_n), sink_pkg::data_t'(store_cnt - first_store));
    check_count("done count", prev_done + 1, {16'h0, rd[31:16]});
  endtask

  task automatic run_transfer(input string name, input sink_pkg::addr_t base, input int size,
                              input sink_pkg::count_t len, input sink_pkg::addr_t stride);
    setup_transfer(name, base, size, len, stride);
    apb_write(sink_pkg::REG_CTRL, 32'h1);
    finish_transfer();
  endtask

  initial begin
    sink_pkg::data_t rd;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    stream_valid_i = 1'b0;
    stream_data_i = '0;
    stream_strb_i = '0;
    @(posedge rst_ni);
    test_name = "reset";
    @(negedge clk_i);
    check_count("mem_req", 0, {31'h0, mem_req_o});
    check_count("stream_ready", 0, {31'h0, stream_ready_o});
    apb_read(sink_pkg::REG_STATUS, rd);
    check_count("status", 0, rd);

    run_transfer("linear", 32'h0000_1000, 8, 16'd8, 32'h0);
    run_transfer("2d", 32'h0000_2000, 9, 16'd3, 32'h40);
    bp_mode = 1'b1; // memory stalls from here on.
    run_transfer("backpressure", 32'h0000_8000, 24, 16'd5, 32'h100);

    // second start lands before any beat, so the sink is busy.
    setup_transfer("start while busy", 32'h0000_4000, 6, 16'd2, 32'h20);
    apb_write(sink_pkg::REG_CTRL, 32'h1);
    apb_read(sink_pkg::REG_STATUS, rd);
    check_count("busy", 1, {31'h0, rd[0]});
    apb_write(sink_pkg::REG_CTRL, 32'h1);
    finish_transfer();

    test_name = "unmapped";
    apb_read(8'h18, rd);
    check_count("pslverr on read", 1, {31'h0, apb_err});
    apb_write(8'h40, 32'hdead_beef);
    check_count("pslverr on write", 1, {31'h0, apb_err});
    apb_read(sink_pkg::REG_BASE, rd);
    check_count("pslverr on base", 0, {31'h0, apb_err});

    run_transfer("size zero", 32'h0000_3000, 0, 16'd1, 32'h0);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/sink_addressgen.sv ====
/*
 * Two-dimensional store address generator.
 * Counts words inside a line and lines inside the transfer; the output
 * address is base + line * stride + word * 4. enable_i steps one word,
 * clear_i returns to the base address. Total size is tracked by the caller.
 */

`default_nettype none

module sink_addressgen (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clear_i,       // back to base.
  input  wire logic             enable_i,      // advance one word.
  input  wire sink_pkg::addr_t  base_i,
  input  wire sink_pkg::count_t line_len_i,    // words per line.
  input  wire sink_pkg::addr_t  line_stride_i, // bytes per line step.
  output sink_pkg::addr_t       addr_o
);

  sink_pkg::count_t word_cnt_q; // word index inside current line.
  sink_pkg::count_t line_cnt_q; // line index.
  sink_pkg::count_t word_nxt;
  logic             line_wrap;

  sink_pkg::addr_t  line_off;
  sink_pkg::addr_t  word_off;

  assign word_nxt  = word_cnt_q + 16'd1;
  assign line_wrap = (word_nxt == line_len_i); // last word of the line.

  // ********************
  // counters.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (clear_i) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (enable_i) begin
      if (line_wrap) begin
        word_cnt_q <= '0;                // wrap to next line.
        line_cnt_q <= line_cnt_q + 16'd1;
      end else begin
        word_cnt_q <= word_nxt;
      end
    end
  end

  // ********************
  // address composition.
  // the product of line and stride is kept to 32 bits.
  assign line_off = sink_pkg::addr_t'(line_cnt_q) * line_stride_i;
  assign word_off = sink_pkg::addr_t'(word_cnt_q) << 2; // 4 bytes per word.
  assign addr_o   = base_i + line_off + word_off;

endmodule

`default_nettype wire

// ==== hdl/sink_apb_regs.sv ====
/*
 * APB register file of the sink.
 * Holds the address pattern configuration, turns a CTRL write into a
 * one-cycle start pulse and reports busy plus a count of finished
 * transfers in STATUS. No wait states.
 */

`default_nettype none

module sink_apb_regs (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                psel_i,
  input  wire logic                penable_i,
  input  wire logic                pwrite_i,
  input  wire sink_pkg::apb_addr_t paddr_i,
  input  wire sink_pkg::data_t     pwdata_i,
  input  wire logic                busy_i,
  input  wire logic                done_i,
  output sink_pkg::data_t          prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output sink_pkg::addr_t          base_o,
  output sink_pkg::count_t         trans_size_o,
  output sink_pkg::count_t         line_len_o,
  output sink_pkg::addr_t          line_stride_o,
  output logic                     start_o
);

  logic             access;   // apb access phase.
  logic             mapped;
  sink_pkg::count_t done_cnt_q;

  assign access   = psel_i & penable_i;
  assign pready_o = 1'b1;

  // ********************
  // read decode.
  always_comb begin
    mapped   = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      sink_pkg::REG_BASE:        prdata_o = base_o;
      sink_pkg::REG_TRANS_SIZE:  prdata_o = {16'h0, trans_size_o};
      sink_pkg::REG_LINE_LEN:    prdata_o = {16'h0, line_len_o};
      sink_pkg::REG_LINE_STRIDE: prdata_o = line_stride_o;
      sink_pkg::REG_CTRL:        prdata_o = '0; // start is write only.
      sink_pkg::REG_STATUS:      prdata_o = {done_cnt_q, 15'h0, busy_i};
      default:                   mapped   = 1'b0;
    endcase
  end

  assign pslverr_o = access & ~mapped;

  // ********************
  // write side.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_o        <= '0;
      trans_size_o  <= '0;
      line_len_o    <= '0;
      line_stride_o <= '0;
      start_o       <= 1'b0;
    end else begin
      start_o <= access & pwrite_i & (paddr_i == sink_pkg::REG_CTRL) & pwdata_i[0];
      if (access && pwrite_i) begin
        case (paddr_i)
          sink_pkg::REG_BASE:        base_o        <= pwdata_i;
          sink_pkg::REG_TRANS_SIZE:  trans_size_o  <= pwdata_i[15:0];
          sink_pkg::REG_LINE_LEN:    line_len_o    <= pwdata_i[15:0];
          sink_pkg::REG_LINE_STRIDE: line_stride_o <= pwdata_i;
          default: ;                 // status and ctrl hold no config.
        endcase
      end
    end
  end

  // completed transfers.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      done_cnt_q <= '0;
    else if (done_i)
      done_cnt_q <= done_cnt_q + 16'd1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) penable_i |-> psel_i)
    else $error("apb penable without psel.");

endmodule

`default_nettype wire

// ==== hdl/sink_pkg.sv ====
/*
 * Shared definitions for the store-stream sink.
 * Widths with a meaning, the streamer state encoding and the APB
 * register map. Modules refer to these by scoped name.
 */

`default_nettype none

package sink_pkg;

  typedef logic [31:0] addr_t;     // byte address into memory.
  typedef logic [31:0] data_t;     // one stream / memory word.
  typedef logic [3:0]  strb_t;     // byte enables of one word.
  typedef logic [15:0] count_t;    // word or line count.
  typedef logic [7:0]  apb_addr_t; // apb register offset.

  // streamer fsm states.
  typedef enum logic {
    SINK_IDLE    = 1'b0,
    SINK_WORKING = 1'b1
  } sink_state_e;

  // ********************
  // register map.
  localparam apb_addr_t REG_BASE        = 8'h00;
  localparam apb_addr_t REG_TRANS_SIZE  = 8'h04; // total words.
  localparam apb_addr_t REG_LINE_LEN    = 8'h08; // words per line.
  localparam apb_addr_t REG_LINE_STRIDE = 8'h0C; // bytes between lines.
  localparam apb_addr_t REG_CTRL        = 8'h10; // bit 0 start, write only.
  localparam apb_addr_t REG_STATUS      = 8'h14; // bit 0 busy, 31:16 done count.

endpackage

`default_nettype wire

// ==== hdl/sink_store_fifo.sv ====
/*
 * Store FIFO between the streamer and the memory port.
 * Holds address, data and strobe per entry. The head entry drives the
 * request/grant store port while the FIFO is not empty; a grant pops it.
 */

`default_nettype none

module sink_store_fifo #(
  parameter int unsigned STORE_FIFO_DEPTH = 4 // at least 2.
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            push_i,
  input  wire sink_pkg::addr_t addr_i,
  input  wire sink_pkg::data_t data_i,
  input  wire sink_pkg::strb_t strb_i,
  input  wire logic            mem_gnt_i,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 mem_req_o,
  output sink_pkg::addr_t      mem_addr_o,
  output sink_pkg::data_t      mem_data_o,
  output sink_pkg::strb_t      mem_be_o
);

  localparam int unsigned PTR_W = $clog2(STORE_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(STORE_FIFO_DEPTH + 1);

  sink_pkg::addr_t addr_mem [STORE_FIFO_DEPTH]; // payload storage.
  sink_pkg::data_t data_mem [STORE_FIFO_DEPTH];
  sink_pkg::strb_t strb_mem [STORE_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(STORE_FIFO_DEPTH));
  assign pop     = mem_req_o & mem_gnt_i;

  // ********************
  // pointers and fill level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) // wrap at depth, which need not be a power of two.
        wr_ptr_q <= (wr_ptr_q == PTR_W'(STORE_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(STORE_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push_i && !pop)
        cnt_q <= cnt_q + 1'b1;
      else if (pop && !push_i)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q] <= addr_i;
      data_mem[wr_ptr_q] <= data_i;
      strb_mem[wr_ptr_q] <= strb_i;
    end
  end

  // head of queue drives the store port.
  assign mem_req_o  = ~empty_o;
  assign mem_addr_o = addr_mem[rd_ptr_q];
  assign mem_data_o = data_mem[rd_ptr_q];
  assign mem_be_o   = strb_mem[rd_ptr_q];

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o))
    else $error("store fifo pushed while full.");

  // request must hold its payload until granted.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o)
      && $stable(mem_data_o) && $stable(mem_be_o))
    else $error("store request changed before grant.");

endmodule

`default_nettype wire

// ==== hdl/sink_streamer.sv ====
/*
 * Sink streamer.
 * An idle/working FSM accepts stream beats, pairs each with the next
 * generated address and pushes it into the store FIFO. After the last
 * beat it waits for the FIFO to drain, pulses done and returns to idle.
 */

`default_nettype none

module sink_streamer #(
  parameter int unsigned STORE_FIFO_DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             start_i,
  input  wire sink_pkg::addr_t  base_i,
  input  wire sink_pkg::count_t trans_size_i,
  input  wire sink_pkg::count_t line_len_i,
  input  wire sink_pkg::addr_t  line_stride_i,
  input  wire logic             stream_valid_i,
  input  wire sink_pkg::data_t  stream_data_i,
  input  wire sink_pkg::strb_t  stream_strb_i,
  input  wire logic             mem_gnt_i,
  output logic                  stream_ready_o,
  output logic                  mem_req_o,
  output sink_pkg::addr_t       mem_addr_o,
  output sink_pkg::data_t       mem_data_o,
  output sink_pkg::strb_t       mem_be_o,
  output logic                  busy_o,
  output logic                  done_o
);

  sink_pkg::sink_state_e state_q, state_d;
  sink_pkg::count_t      beat_cnt_q; // beats accepted so far.
  sink_pkg::addr_t       gen_addr;

  logic fifo_full, fifo_empty;
  logic all_accepted; // every beat of the transfer is in.
  logic beat_fire;

  assign all_accepted   = (beat_cnt_q == trans_size_i);
  assign stream_ready_o = (state_q == sink_pkg::SINK_WORKING) & ~fifo_full & ~all_accepted;
  assign beat_fire      = stream_valid_i & stream_ready_o;
  assign busy_o         = (state_q == sink_pkg::SINK_WORKING);

  // ********************
  // fsm.
  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    case (state_q)
      sink_pkg::SINK_IDLE: begin
        if (start_i)
          state_d = sink_pkg::SINK_WORKING;
      end
      sink_pkg::SINK_WORKING: begin
        if (all_accepted && fifo_empty) begin // all stores drained or size 0.
          done_o  = 1'b1;
          state_d = sink_pkg::SINK_IDLE;
        end
      end
      default: state_d = sink_pkg::SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= sink_pkg::SINK_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (done_o)
        beat_cnt_q <= '0;          // ready for next transfer.
      else if (beat_fire)
        beat_cnt_q <= beat_cnt_q + 16'd1;
    end
  end

  sink_addressgen u_addressgen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( done_o        ), // rewind at end of transfer.
    .enable_i      ( beat_fire     ),
    .base_i        ( base_i        ),
    .line_len_i    ( line_len_i    ),
    .line_stride_i ( line_stride_i ),
    .addr_o        ( gen_addr      )
  );

  sink_store_fifo #(
    .STORE_FIFO_DEPTH ( STORE_FIFO_DEPTH )
  ) u_store_fifo (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .push_i     ( beat_fire     ),
    .addr_i     ( gen_addr      ),
    .data_i     ( stream_data_i ),
    .strb_i     ( stream_strb_i ),
    .mem_gnt_i  ( mem_gnt_i     ),
    .full_o     ( fifo_full     ),
    .empty_o    ( fifo_empty    ),
    .mem_req_o  ( mem_req_o     ),
    .mem_addr_o ( mem_addr_o    ),
    .mem_data_o ( mem_data_o    ),
    .mem_be_o   ( mem_be_o      )
  );

endmodule

`default_nettype wire

// ==== hdl/sink_top.sv ====
/*
 * Top of the store-stream sink.
 * APB configuration registers feeding the sink streamer, which
 * writes the incoming stream to memory through the store port.
 */

`default_nettype none

module sink_top #(
  parameter int unsigned STORE_FIFO_DEPTH = 4 // store fifo entries.
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // apb slave.
  input  wire logic                psel_i,
  input  wire logic                penable_i,
  input  wire logic                pwrite_i,
  input  wire sink_pkg::apb_addr_t paddr_i,
  input  wire sink_pkg::data_t     pwdata_i,
  output sink_pkg::data_t          prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // stream in.
  input  wire logic                stream_valid_i,
  input  wire sink_pkg::data_t     stream_data_i,
  input  wire sink_pkg::strb_t     stream_strb_i,
  output logic                     stream_ready_o,
  // store port.
  output logic                     mem_req_o,
  output sink_pkg::addr_t          mem_addr_o,
  output sink_pkg::data_t          mem_data_o,
  output sink_pkg::strb_t          mem_be_o,
  input  wire logic                mem_gnt_i
);

  sink_pkg::addr_t  base, line_stride;
  sink_pkg::count_t trans_size, line_len;
  logic             start, busy, done;

  sink_apb_regs u_regs (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .busy_i        ( busy        ),
    .done_i        ( done        ),
    .prdata_o, .pready_o, .pslverr_o,
    .base_o        ( base        ),
    .trans_size_o  ( trans_size  ),
    .line_len_o    ( line_len    ),
    .line_stride_o ( line_stride ),
    .start_o       ( start       )
  );

  sink_streamer #(
    .STORE_FIFO_DEPTH ( STORE_FIFO_DEPTH )
  ) u_streamer (
    .clk_i, .rst_ni,
    .start_i       ( start       ),
    .base_i        ( base        ),
    .trans_size_i  ( trans_size  ),
    .line_len_i    ( line_len    ),
    .line_stride_i ( line_stride ),
    .stream_valid_i, .stream_data_i, .stream_strb_i, .mem_gnt_i,
    .stream_ready_o, .mem_req_o, .mem_addr_o, .mem_data_o, .mem_be_o,
    .busy_o        ( busy        ),
    .done_o        ( done        )
  );

endmodule

`default_nettype wire

// ==== src.f ====
hdl/sink_pkg.sv
hdl/sink_addressgen.sv
hdl/sink_store_fifo.sv
hdl/sink_streamer.sv
hdl/sink_apb_regs.sv
hdl/sink_top.sv
dv/tb_clkgen.sv
dv/tb_sink.sv
